// ==== project.f ====
+incdir+rtl
+incdir+tb
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/pipeline_cpu.sv
tb/tb_pipeline_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_pipeline_cpu -o tb_pipeline_cpu
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_pipeline_cpu
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

// ==== tb/cpu_tests.svh ====
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

task automatic verify_reset_state();
  test_name = "reset state";
  compare_value("instr_ready", 32'd1, 32'(instr_ready));
  compare_value("commit_valid", 32'd0, 32'(commit_valid));
  send_word(arith_word(1'b0, OP_INC, 3'd0, 3'd0, 16'h0000));
  wait_for_commits();
  compare_value("r0 plus one", 32'd1, last_commit.data);  // Cleared register
endtask

task automatic write_half_words();
  test_name = "half-word writes";
  send_word(arith_word(1'b1, OP_MOVE_LOW, 3'd2, 3'd0, 16'h1234));
  send_word(arith_word(1'b1, OP_MOVE_HIGH, 3'd2, 3'd0, 16'habcd));
  send_word(arith_word(1'b0, OP_MOVE_REG, 3'd5, 3'd2, 16'h0000));
  wait_for_commits();
  compare_value("merged word", 32'habcd1234, last_commit.data);
  compare_value("merged mask", 32'd3, 32'(last_commit.wen));
endtask

task automatic run_arithmetic();
  test_name = "arithmetic";
  send_word(arith_word(1'b1, OP_MOVE_REG, 3'd1, 3'd0, 16'hffff));
  send_word(arith_word(1'b1, OP_MOVE_HIGH, 3'd1, 3'd0, 16'hffff));  // r1 all ones
  send_word(arith_word(1'b1, OP_ADD, 3'd1, 3'd0, 16'h0002));        // Wraps to 1
  send_word(arith_word(1'b0, OP_ADD, 3'd3, 3'd1, 16'h0000));
  send_word(arith_word(1'b0, OP_INC, 3'd4, 3'd0, 16'h0000));
  send_word(arith_word(1'b0, 3'b010, 3'd6, 3'd0, 16'h0000));
  wait_for_commits();
  compare_value("operation 010", 32'd0, last_commit.data);
endtask

task automatic provoke_hazard_stall();
  int n;
  test_name = "hazard stall";
  stall_seen = 1'b0;
  send_word(arith_word(1'b0, OP_INC, 3'd1, 3'd0, 16'h0000));
  send_word(arith_word(1'b0, OP_INC, 3'd1, 3'd0, 16'h0000));
  send_word(arith_word(1'b0, OP_ADD, 3'd2, 3'd1, 16'h0000));
  compare_value("instr_ready dropped", 32'd1, 32'(stall_seen));
  wait_for_commits();
  // Independent pair commits one edge apart without a stall
  stall_seen = 1'b0;
  send_word(arith_word(1'b0, OP_INC, 3'd3, 3'd0, 16'h0000));
  send_word(arith_word(1'b0, OP_INC, 3'd4, 3'd0, 16'h0000));
  wait_for_commits();
  n = commit_edges.size();
  compare_value("independent stall", 32'd0, 32'(stall_seen));
  compare_value("commit spacing", 32'd1, 32'(commit_edges[n-1] - commit_edges[n-2]));
endtask

task automatic measure_latency_and_nops();
  int accept_edge;
  test_name = "latency and no-ops";
  idle_cycles(4);
  send_word(arith_word(1'b0, OP_INC, 3'd7, 3'd0, 16'h0000));
  accept_edge = last_accept_edge;
  wait_for_commits();
  // Fourth edge counting the acceptance edge itself
  compare_value("commit edge", 32'(accept_edge + 3), 32'(commit_edges[commit_edges.size()-1]));
  send_word(class_word(CLASS_NOP, OP_INC, 3'd7));
  send_word(class_word(CLASS_MEMORY, OP_ADD, 3'd7));
  send_word(class_word(CLASS_AUDIO, OP_MOVE_REG, 3'd7));
  idle_cycles(8);
  send_word(arith_word(1'b0, OP_INC, 3'd7, 3'd0, 16'h0000));
  wait_for_commits();
  compare_value("r7 after no-ops", 32'd2, last_commit.data);
endtask

task automatic stream_random_words();
  logic [31:0] word;
  test_name = "random stream";
  for (int n = 0; n < RANDOM_WORDS; n++) begin
    word = $urandom;
    word[30:29] = CLASS_ARITH;  // Any operation including the moves
    send_word(word);
    idle_cycles($urandom_range(0, 2));
  end
  wait_for_commits();
endtask

`endif

// ==== tb/tb_pipeline_cpu.sv ====
`default_nettype none

module tb_pipeline_cpu;
  import cpu_pkg::*;

  localparam int CLOCK_PERIOD    = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_WORDS  = 20;
  localparam int RANDOM_WORDS    = 200;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * (DIRECTED_WORDS + RANDOM_WORDS);

  logic        clock = 1'b0;
  logic        reset;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] instr_word;
  logic        commit_valid;
  commit_t     commit;

  logic [31:0] model_regs [8];    // Register state as the program order sees it
  commit_t     expected_q [$];
  commit_t     expected;
  commit_t     last_commit;
  int          commit_edges [$];  // Edge number of every commit in order
  int          edge_count = 0;
  int          last_accept_edge;
  logic        stall_seen;
  string       test_name;

  pipeline_cpu i_pipeline_cpu (
    .clock        (clock),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr_word),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  initial begin
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    forever begin
      @(posedge clock);
      edge_count++;
    end
  end

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic compare_value(string what, logic [31:0] expected_value,
                               logic [31:0] actual_value);
    if (actual_value !== expected_value) begin
      fail_run($sformatf("mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, expected_value, actual_value));
    end
  endtask

  // Fields from the top bit are flag, class, op, unused, rs1, rs2 and imm
  task automatic apply_model(logic [31:0] word);
    logic        imm_flag;
    logic [2:0]  op;
    logic [2:0]  rd;
    logic [2:0]  rs2;
    logic [31:0] src2;
    logic [31:0] value;
    logic [1:0]  mask;
    commit_t     entry;
    imm_flag = word[31];
    op       = word[28:26];
    rd       = word[21:19];
    rs2      = word[18:16];
    src2     = imm_flag ? {16'h0000, word[15:0]} : model_regs[rs2];
    if (word[30:29] == 2'b01) begin  // Only ARITH words write
      mask = 2'b11;
      case (op)
        3'b001:  value = model_regs[rd] + src2;
        3'b011:  value = model_regs[rd] + 32'd1;
        3'b101: begin
          value = src2;
          mask  = 2'b01;
        end
        3'b110: begin
          value = imm_flag ? {word[15:0], 16'h0000} : model_regs[rs2];
          mask  = 2'b10;
        end
        3'b111:  value = src2;
        default: value = 32'd0;
      endcase
      entry.rd   = rd;
      entry.wen  = mask;
      entry.data = 32'd0;  // Unwritten halves report zero
      if (mask[0]) begin
        model_regs[rd][15:0] = value[15:0];
        entry.data[15:0]     = value[15:0];
      end
      if (mask[1]) begin
        model_regs[rd][31:16] = value[31:16];
        entry.data[31:16]     = value[31:16];
      end
      expected_q.push_back(entry);
    end
  endtask

  // Returns on the falling edge after the accepting edge
  task automatic send_word(logic [31:0] word);
    instr_valid = 1'b1;
    instr_word  = word;
    while (!instr_ready) begin
      stall_seen = 1'b1;
      @(negedge clock);
    end
    last_accept_edge = edge_count + 1;
    apply_model(word);
    @(negedge clock);
    instr_valid = 1'b0;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) @(negedge clock);
  endtask

  task automatic wait_for_commits();
    while (expected_q.size() != 0) @(negedge clock);
  endtask

  function automatic logic [31:0] arith_word(logic imm_flag, logic [2:0] op, logic [2:0] rd,
                                             logic [2:0] rs2, logic [15:0] imm);
    return {imm_flag, CLASS_ARITH, op, 4'b0000, rd, rs2, imm};
  endfunction

  function automatic logic [31:0] class_word(logic [1:0] iclass, logic [2:0] op,
                                             logic [2:0] rd);
    return {1'b0, iclass, op, 4'b0000, rd, 3'd0, 16'h0000};
  endfunction

  `include "cpu_tests.svh"

  // Commit monitor
  initial begin
    forever begin
      @(negedge clock);
      if (!reset && commit_valid) begin
        if (expected_q.size() == 0) begin
          fail_run("commit_valid rose although no register write was pending");
        end else begin
          expected = expected_q.pop_front();
          compare_value("commit rd", 32'(expected.rd), 32'(commit.rd));
          compare_value("commit wen", 32'(expected.wen), 32'(commit.wen));
          compare_value("commit data", expected.data, commit.data);
          last_commit = commit;
          commit_edges.push_back(edge_count);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    fail_run("watchdog expired before the test sequence finished");
  end

  initial begin
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr_word  = '0;
    stall_seen  = 1'b0;
    test_name   = "startup";
    for (int i = 0; i < 8; i++) begin
      model_regs[i] = 32'd0;
    end
    void'($urandom(85615));
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    verify_reset_state();
    write_half_words();
    run_arithmetic();
    provoke_hazard_stall();
    measure_latency_and_nops();
    stream_random_words();

    if (expected_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("commits were still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pipeline_cpu.sv ====
`default_nettype none

module pipeline_cpu (
  input  wire                  clock,
  input  wire                  reset,
  input  wire                  instr_valid,
  output logic                 instr_ready,
  input  wire cpu_pkg::instr_t instr,
  output logic                 commit_valid,
  output cpu_pkg::commit_t     commit
);
  import cpu_pkg::*;

  reg_addr_t  rd_addr_a;
  reg_addr_t  rd_addr_b;
  word_t      rd_data_a;
  word_t      rd_data_b;
  reg_addr_t  wr_addr;
  half_mask_t wr_mask;
  word_t      wr_data;
  instr_t     id_instr;
  logic       id_valid;
  id_ex_t     id_ex;
  ex_wb_t     ex_wb;
  logic       stall;

  assign instr_ready = !stall;  // Hazards push back on the stream

  reg_file i_reg_file (
    .clock     (clock),
    .reset     (reset),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_addr   (wr_addr),
    .wr_mask   (wr_mask),
    .wr_data   (wr_data)
  );

  hazard_unit i_hazard_unit (
    .id_instr (id_instr),
    .id_valid (id_valid),
    .ex_rd    (id_ex.rd),
    .ex_wen   (id_ex.wen),
    .wb_rd    (ex_wb.rd),
    .wb_wen   (ex_wb.wen),
    .stall    (stall)
  );

  decode_stage i_decode_stage (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .id_instr    (id_instr),
    .id_valid    (id_valid),
    .id_ex       (id_ex)
  );

  execute_stage i_execute_stage (
    .clock (clock),
    .reset (reset),
    .id_ex (id_ex),
    .ex_wb (ex_wb)
  );

  writeback_stage i_writeback_stage (
    .clock        (clock),
    .reset        (reset),
    .ex_wb        (ex_wb),
    .wr_addr      (wr_addr),
    .wr_mask      (wr_mask),
    .wr_data      (wr_data),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

endmodule

`default_nettype wire

// ==== rtl/writeback_stage.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module writeback_stage (
  input  wire                  clock,
  input  wire                  reset,
  input  wire cpu_pkg::ex_wb_t ex_wb,
  output cpu_pkg::reg_addr_t   wr_addr,
  output cpu_pkg::half_mask_t  wr_mask,
  output cpu_pkg::word_t       wr_data,
  output logic                 commit_valid,
  output cpu_pkg::commit_t     commit
);
  import cpu_pkg::*;

  word_t written;

  assign wr_addr = ex_wb.rd;
  assign wr_mask = ex_wb.valid ? ex_wb.wen : 2'b00;
  assign wr_data = ex_wb.result;

  // Keep only the halves that reach the register file
  assign written = wr_data & {{`CPU_HALF_WIDTH{wr_mask[1]}}, {`CPU_HALF_WIDTH{wr_mask[0]}}};

  // Commit report, one cycle after the register write
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      commit_valid <= 1'b0;
      commit       <= '0;
    end else begin
      commit_valid <= |wr_mask;
      commit.rd    <= wr_addr;
      commit.wen   <= wr_mask;
      commit.data  <= written;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  wire                  clock,
  input  wire                  reset,
  input  wire cpu_pkg::id_ex_t id_ex,
  output cpu_pkg::ex_wb_t      ex_wb
);
  import cpu_pkg::*;

  word_t  alu_result;
  ex_wb_t ex_wb_next;

  // ALU, unknown operations give zero
  always_comb begin
    case (id_ex.alu_op)
      OP_ADD:  alu_result = id_ex.operand1 + id_ex.operand2;
      OP_INC:  alu_result = id_ex.operand1 + word_t'(1);
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    ex_wb_next.valid  = id_ex.valid;
    ex_wb_next.rd     = id_ex.rd;
    ex_wb_next.wen    = id_ex.wen;
    // Moves carry their value in operand2
    ex_wb_next.result = id_ex.is_move ? id_ex.operand2 : alu_result;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ex_wb <= '0;
    end else begin
      ex_wb <= ex_wb_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     instr_valid,
  input  wire cpu_pkg::instr_t    instr,
  input  wire                     stall,
  output cpu_pkg::reg_addr_t      rd_addr_a,
  output cpu_pkg::reg_addr_t      rd_addr_b,
  input  wire cpu_pkg::word_t     rd_data_a,
  input  wire cpu_pkg::word_t     rd_data_b,
  output cpu_pkg::instr_t         id_instr,
  output logic                    id_valid,
  output cpu_pkg::id_ex_t         id_ex
);
  import cpu_pkg::*;

  logic       is_move;
  logic       is_alu;
  logic       issue;
  word_t      operand2;
  half_mask_t wen;
  id_ex_t     id_ex_next;

  // Instruction register, frozen while stalled
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (!stall) begin
      id_valid <= instr_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      id_instr <= instr;
    end
  end

  assign is_move = is_move_instr(id_instr);
  assign is_alu  = is_alu_instr(id_instr);

  assign rd_addr_a = id_instr.rs1;
  assign rd_addr_b = id_instr.rs2;

  // Second operand, immediate placed by operation when the flag is set
  always_comb begin
    if (!id_instr.imm_flag) begin
      operand2 = rd_data_b;
    end else if (is_move && (id_instr.op == OP_MOVE_HIGH)) begin
      operand2 = {id_instr.imm, {`CPU_HALF_WIDTH{1'b0}}};
    end else begin
      operand2 = {{`CPU_HALF_WIDTH{1'b0}}, id_instr.imm};  // Zero-extended
    end
  end

  // Half-word write enables
  always_comb begin
    if (is_move && (id_instr.op == OP_MOVE_LOW)) begin
      wen = 2'b01;
    end else if (is_move && (id_instr.op == OP_MOVE_HIGH)) begin
      wen = 2'b10;
    end else if (is_alu || is_move) begin
      wen = 2'b11;
    end else begin
      wen = 2'b00;  // NOP, MEMORY and AUDIO
    end
  end

  assign issue = id_valid && !stall;  // Bubble otherwise

  always_comb begin
    id_ex_next.valid    = issue;
    id_ex_next.is_move  = is_move;
    id_ex_next.alu_op   = id_instr.op;
    id_ex_next.operand1 = rd_data_a;
    id_ex_next.operand2 = operand2;
    id_ex_next.rd       = id_instr.rs1;
    id_ex_next.wen      = issue ? wen : 2'b00;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  input  wire cpu_pkg::instr_t     id_instr,
  input  wire                      id_valid,
  input  wire cpu_pkg::reg_addr_t  ex_rd,
  input  wire cpu_pkg::half_mask_t ex_wen,
  input  wire cpu_pkg::reg_addr_t  wb_rd,
  input  wire cpu_pkg::half_mask_t wb_wen,
  output logic                     stall
);
  import cpu_pkg::*;

  logic reads_rs1;
  logic reads_rs2;
  logic ex_busy;
  logic wb_busy;
  logic rs1_pending;
  logic rs2_pending;

  // Sources the decoding word actually reads
  assign reads_rs1 = is_alu_instr(id_instr);
  assign reads_rs2 = (is_alu_instr(id_instr) || is_move_instr(id_instr)) &&
                     !id_instr.imm_flag;

  // A stage owes a write only if it has some half enabled
  assign ex_busy = |ex_wen;
  assign wb_busy = |wb_wen;

  assign rs1_pending = (ex_busy && (ex_rd == id_instr.rs1)) ||
                       (wb_busy && (wb_rd == id_instr.rs1));
  assign rs2_pending = (ex_busy && (ex_rd == id_instr.rs2)) ||
                       (wb_busy && (wb_rd == id_instr.rs2));

  // Writes retire on the same edge the reader would latch, so two stages suffice
  assign stall = id_valid &&
                 ((reads_rs1 && rs1_pending) || (reads_rs2 && rs2_pending));

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module reg_file (
  input  wire                      clock,
  input  wire                      reset,
  input  wire cpu_pkg::reg_addr_t  rd_addr_a,
  input  wire cpu_pkg::reg_addr_t  rd_addr_b,
  output cpu_pkg::word_t           rd_data_a,
  output cpu_pkg::word_t           rd_data_b,
  input  wire cpu_pkg::reg_addr_t  wr_addr,
  input  wire cpu_pkg::half_mask_t wr_mask,
  input  wire cpu_pkg::word_t      wr_data
);
  import cpu_pkg::*;

  word_t regs [`CPU_NUM_REGS];

  // No bypass, the hazard unit holds readers until the write has landed
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_mask[0]) begin  // Lower half
        regs[wr_addr][`CPU_HALF_WIDTH-1:0] <= wr_data[`CPU_HALF_WIDTH-1:0];
      end
      if (wr_mask[1]) begin  // Upper half
        regs[wr_addr][`CPU_DATA_WIDTH-1:`CPU_HALF_WIDTH] <=
          wr_data[`CPU_DATA_WIDTH-1:`CPU_HALF_WIDTH];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`CPU_DATA_WIDTH-1:0]     word_t;
  typedef logic [1:0]                     half_mask_t;  // Bit 1 upper, bit 0 lower

  typedef enum logic [1:0] {
    CLASS_NOP    = 2'b00,
    CLASS_ARITH  = 2'b01,
    CLASS_MEMORY = 2'b10,  // Decodes as a no-op
    CLASS_AUDIO  = 2'b11   // Decodes as a no-op
  } instr_class_e;

  // Moves share the ARITH class and use the top operation codes
  typedef enum logic [2:0] {
    OP_ADD       = 3'b001,
    OP_INC       = 3'b011,
    OP_MOVE_LOW  = 3'b101,
    OP_MOVE_HIGH = 3'b110,
    OP_MOVE_REG  = 3'b111
  } op_e;

  typedef struct packed {
    logic                         imm_flag;
    instr_class_e                 iclass;
    op_e                          op;
    logic [3:0]                   unused;
    reg_addr_t                    rs1;  // Also the destination
    reg_addr_t                    rs2;
    logic [`CPU_HALF_WIDTH-1:0]   imm;
  } instr_t;

  typedef struct packed {
    logic       valid;
    logic       is_move;
    op_e        alu_op;
    word_t      operand1;
    word_t      operand2;
    reg_addr_t  rd;
    half_mask_t wen;
  } id_ex_t;

  typedef struct packed {
    logic       valid;
    reg_addr_t  rd;
    half_mask_t wen;
    word_t      result;
  } ex_wb_t;

  typedef struct packed {
    reg_addr_t  rd;
    half_mask_t wen;
    word_t      data;  // Unwritten halves read as zero
  } commit_t;

  function automatic logic is_move_instr(instr_t i);
    return (i.iclass == CLASS_ARITH) &&
           (i.op inside {OP_MOVE_LOW, OP_MOVE_HIGH, OP_MOVE_REG});
  endfunction

  function automatic logic is_alu_instr(instr_t i);
    return (i.iclass == CLASS_ARITH) && !is_move_instr(i);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Register and operand width
`define CPU_DATA_WIDTH 32

// Each register is written per half word
`define CPU_HALF_WIDTH 16

// Size of the register file
`define CPU_NUM_REGS 8

// Bits in a register number, must cover CPU_NUM_REGS
`define CPU_REG_ADDR_WIDTH 3

`endif
